// ==== common/cache_params.svh ====
/* cache geometry; the replacement tree is fixed to 4 ways
   a line address is the word address without its word-select bits */
`ifndef CACHE_PARAMS_SVH
`define CACHE_PARAMS_SVH

`define CACHE_WAYS    4
`define CACHE_INDEX_W 4
`define CACHE_ADDR_W  25  // word address
`define CACHE_WORDS   4   // words per line
`define CACHE_WORD_W  32

`endif

// ==== common/cache_pkg.sv ====
/* shared types for the cache and its testbench
   all widths follow the macros in cache_params.svh */
`include "cache_params.svh"

package cache_pkg;

    typedef logic [`CACHE_WORD_W-1:0]                 word_t;
    typedef logic [`CACHE_WORDS*`CACHE_WORD_W-1:0]    line_t;
    typedef logic [`CACHE_ADDR_W-1:0]                 p_addr_t;
    typedef logic [`CACHE_ADDR_W-$clog2(`CACHE_WORDS)-1:0] line_addr_t;
    typedef logic [`CACHE_INDEX_W-1:0]                index_t;
    typedef logic [$bits(line_addr_t)-`CACHE_INDEX_W-1:0] tag_t;
    typedef logic [`CACHE_WAYS-1:0]                   way_sel_t;  // one-hot
    typedef logic [$clog2(`CACHE_WAYS)-1:0]           way_num_t;

    typedef struct packed {
        logic dirty;
        logic valid;
        tag_t tag;
    } tag_entry_t;

    // processor request, held while waitrequest is high
    typedef struct packed {
        p_addr_t                      addr;
        logic [`CACHE_WORD_W/8-1:0]   byte_en;
        word_t                        writedata;
        logic                         read;
        logic                         write;
    } p_req_t;

    typedef struct packed {
        line_addr_t addr;
        line_t      writedata;
        logic       read;
        logic       write;
    } m_req_t;

    typedef struct packed {
        logic hit;
        logic valid;
        logic dirty;
    } way_stat_t;

endpackage

// ==== cache/cache_ram.sv ====
/* registered read, write-first on a same-index write
   no reset; contents are undefined until written */
module cache_ram #(
    parameter type entry_t = logic,
    parameter int  depth_w = $bits(cache_pkg::index_t)
) (
    input  logic              clk,
    input  logic              i_wr_en,
    input  cache_pkg::index_t i_wr_index,
    input  entry_t            i_wr_data,
    input  cache_pkg::index_t i_rd_index,
    output entry_t            o_rd_data
);

    entry_t mem [2**depth_w];

    always_ff @(posedge clk) begin
        if (i_wr_en) mem[i_wr_index] <= i_wr_data;
        // bypass so a fill is visible to the next merge
        if (i_wr_en && (i_wr_index == i_rd_index)) o_rd_data <= i_wr_data;
        else o_rd_data <= mem[i_rd_index];
    end

endmodule

// ==== cache/cache_way.sv ====
/* one way: data line RAM plus tag RAM
   a write strobe with no word enabled clears the entry (reset sweep) */
`include "cache_params.svh"

module cache_way (
    input  logic                        clk,
    input  cache_pkg::index_t           i_index,
    input  cache_pkg::tag_t             i_tag,
    input  logic                        i_write,
    input  logic                        i_fill,     // fill for a read, stays clean
    input  logic [`CACHE_WORDS-1:0]     i_word_en,
    input  logic [`CACHE_WORD_W/8-1:0]  i_byte_en,
    input  cache_pkg::line_t            i_wr_line,
    output cache_pkg::line_t            o_rd_line,
    output cache_pkg::way_stat_t        o_stat,
    output cache_pkg::line_addr_t       o_wb_addr
);
    import cache_pkg::*;

    tag_entry_t tag_rd;
    tag_entry_t tag_wr;
    line_t      line_wr;

    // byte lanes of the enabled words replace the stored line
    always_comb begin
        line_wr = o_rd_line;
        for (int w = 0; w < `CACHE_WORDS; w++) begin
            for (int b = 0; b < `CACHE_WORD_W/8; b++) begin
                if (i_word_en[w] && i_byte_en[b])
                    line_wr[w*`CACHE_WORD_W + b*8 +: 8] = i_wr_line[w*`CACHE_WORD_W + b*8 +: 8];
            end
        end
    end

    assign tag_wr.valid = |i_word_en;
    assign tag_wr.dirty = (|i_word_en) && !i_fill;
    assign tag_wr.tag   = i_tag;

    cache_ram #(.entry_t(line_t)) data_ram_inst (
        .clk        (clk),
        .i_wr_en    (i_write && (|i_word_en)),
        .i_wr_index (i_index),
        .i_wr_data  (line_wr),
        .i_rd_index (i_index),
        .o_rd_data  (o_rd_line)
    );

    cache_ram #(.entry_t(tag_entry_t)) tag_ram_inst (
        .clk        (clk),
        .i_wr_en    (i_write),
        .i_wr_index (i_index),
        .i_wr_data  (tag_wr),
        .i_rd_index (i_index),
        .o_rd_data  (tag_rd)
    );

    assign o_stat = '{hit:   tag_rd.valid && (tag_rd.tag == i_tag),
                      valid: tag_rd.valid,
                      dirty: tag_rd.dirty};
    assign o_wb_addr = {tag_rd.tag, i_index};  // index held since the compare

endmodule

// ==== cache/plru_tree.sv ====
/* 3-bit tree pseudo-LRU for 4 ways
   victim is valid one cycle after the index; bits change on the access edge */
module plru_tree (
    input  logic                clk,
    input  cache_pkg::index_t   i_index,
    input  logic                i_clear,
    input  logic                i_access,
    input  cache_pkg::way_num_t i_way,
    output cache_pkg::way_num_t o_victim
);

    logic [2:0] lru_rd;
    logic [2:0] lru_wr;

    // bit 0 picks the older half, bit 1 ways 0/1, bit 2 ways 2/3
    always_comb begin
        lru_wr    = lru_rd;
        lru_wr[0] = ~i_way[1];  // point at the other half
        if (i_way[1])
            lru_wr[2] = ~i_way[0];
        else
            lru_wr[1] = ~i_way[0];
        if (i_clear) lru_wr = '0;
    end

    cache_ram #(.entry_t(logic [2:0])) lru_ram_inst (
        .clk        (clk),
        .i_wr_en    (i_access || i_clear),
        .i_wr_index (i_index),
        .i_wr_data  (lru_wr),
        .i_rd_index (i_index),
        .o_rd_data  (lru_rd)
    );

    assign o_victim = lru_rd[0] ? {1'b1, lru_rd[2]} : {1'b0, lru_rd[1]};

endmodule

// ==== cache/cache_ctrl.sv ====
/* one processor request and one memory transaction in flight
   waitrequest stays high for the whole reset sweep, one index per cycle */
`include "cache_params.svh"

module cache_ctrl (
    input  logic                        clk,
    input  logic                        rst,
    input  cache_pkg::p_req_t           i_p_req,
    output logic                        o_p_waitrequest,
    output cache_pkg::word_t            o_p_readdata,
    output logic                        o_p_readdata_valid,
    output cache_pkg::m_req_t           o_m_req,
    input  cache_pkg::line_t            i_m_readdata,
    input  logic                        i_m_readdata_valid,
    input  logic                        i_m_waitrequest,
    output cache_pkg::index_t           o_index,
    output cache_pkg::tag_t             o_tag,
    output cache_pkg::way_sel_t         o_write,
    output logic                        o_fill,
    output logic [`CACHE_WORDS-1:0]     o_word_en,
    output logic [`CACHE_WORD_W/8-1:0]  o_byte_en,
    output cache_pkg::line_t            o_wr_line,
    input  cache_pkg::way_stat_t        i_stat [`CACHE_WAYS],
    input  cache_pkg::line_t            i_rd_line [`CACHE_WAYS],
    input  cache_pkg::line_addr_t       i_wb_addr [`CACHE_WAYS],
    output logic                        o_lru_clear,
    output logic                        o_lru_access,
    output cache_pkg::way_num_t         o_lru_way,
    input  cache_pkg::way_num_t         i_victim
);
    import cache_pkg::*;

    localparam int wsel_w = $clog2(`CACHE_WORDS);

    typedef logic [`CACHE_WORDS-1:0] word_en_t;
    typedef enum logic [3:0] {
        SWEEP, IDLE, COMP, HIT, FETCH1, FETCH2, FETCH3, WB1, WB2
    } state_t;

    state_t            state;
    index_t            sweep_idx;
    p_req_t            req_q;
    way_num_t          way_q;     // way being written or evicted
    logic              m_read;
    logic              m_write;
    line_addr_t        m_addr;
    line_t             m_wdata;
    p_addr_t           cur_addr;
    line_addr_t        cur_line;
    line_addr_t        req_line;
    logic [wsel_w-1:0] word_sel;
    way_sel_t          hit_vec;
    way_sel_t          valid_vec;
    way_num_t          hit_num;
    way_num_t          inv_num;
    way_num_t          repl_num;
    logic              any_hit;

    function automatic word_t word_of(line_t line, logic [wsel_w-1:0] sel);
        return line[sel*`CACHE_WORD_W +: `CACHE_WORD_W];
    endfunction

    assign cur_addr = (state == IDLE) ? i_p_req.addr : req_q.addr;
    assign cur_line = cur_addr[`CACHE_ADDR_W-1:wsel_w];
    assign req_line = req_q.addr[`CACHE_ADDR_W-1:wsel_w];
    assign word_sel = req_q.addr[wsel_w-1:0];
    assign o_index  = (state == SWEEP) ? sweep_idx : cur_line[`CACHE_INDEX_W-1:0];
    assign o_tag    = cur_line[$bits(line_addr_t)-1:`CACHE_INDEX_W];

    // lowest numbered hit and invalid way
    always_comb begin
        hit_num = '0;
        inv_num = '0;
        for (int w = `CACHE_WAYS-1; w >= 0; w--) begin
            hit_vec[w]   = i_stat[w].hit;
            valid_vec[w] = i_stat[w].valid;
            if (i_stat[w].hit) hit_num = way_num_t'(w);
            if (!i_stat[w].valid) inv_num = way_num_t'(w);
        end
    end

    assign any_hit  = |hit_vec;
    assign repl_num = (&valid_vec) ? i_victim : inv_num;

    always_comb begin
        o_write = '0;
        case (state)
            SWEEP:       o_write = '1;
            HIT, FETCH3: o_write = way_sel_t'(1) << way_q;
            FETCH2:      if (i_m_readdata_valid) o_write = way_sel_t'(1) << way_q;
            default:     ;
        endcase
    end

    assign o_word_en = (state == SWEEP)  ? '0 :
                       (state == FETCH2) ? '1 : word_en_t'(1) << word_sel;
    assign o_byte_en = (state == FETCH2) ? '1 : req_q.byte_en;
    assign o_fill    = (state == FETCH2) && req_q.read;
    assign o_wr_line = (state == FETCH2) ? i_m_readdata : {`CACHE_WORDS{req_q.writedata}};

    assign o_lru_clear  = (state == SWEEP);
    assign o_lru_access = (state == COMP);
    assign o_lru_way    = any_hit ? hit_num : repl_num;

    assign o_p_waitrequest = (state != IDLE);
    assign o_m_req = '{addr: m_addr, writedata: m_wdata, read: m_read, write: m_write};

    always_ff @(posedge clk) begin
        if (rst) begin
            state              <= SWEEP;
            sweep_idx          <= '0;
            m_read             <= 1'b0;
            m_write            <= 1'b0;
            o_p_readdata_valid <= 1'b0;
        end else begin
            o_p_readdata_valid <= 1'b0;  // single-cycle pulse
            case (state)
                SWEEP: begin
                    sweep_idx <= sweep_idx + 1'b1;
                    if (&sweep_idx) state <= IDLE;
                end
                IDLE: if (i_p_req.read || i_p_req.write) state <= COMP;
                COMP: begin
                    if (any_hit && req_q.write) begin
                        state <= HIT;
                    end else if (any_hit) begin
                        state              <= IDLE;
                        o_p_readdata_valid <= 1'b1;
                    end else if (valid_vec[repl_num] && i_stat[repl_num].dirty) begin
                        state <= WB1;
                    end else begin
                        state  <= FETCH1;
                        m_read <= 1'b1;
                    end
                end
                HIT, FETCH3: state <= IDLE;
                FETCH1: begin
                    if (!i_m_waitrequest) begin
                        m_read <= 1'b0;
                        state  <= FETCH2;
                    end
                end
                FETCH2: begin
                    if (i_m_readdata_valid && req_q.write) begin
                        state <= FETCH3;  // merge the write word next
                    end else if (i_m_readdata_valid) begin
                        state              <= IDLE;
                        o_p_readdata_valid <= 1'b1;
                    end
                end
                WB1: begin
                    m_write <= 1'b1;
                    state   <= WB2;
                end
                WB2: begin
                    if (!i_m_waitrequest) begin
                        m_write <= 1'b0;
                        m_read  <= 1'b1;
                        state   <= FETCH1;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (state)
            IDLE: req_q <= i_p_req;
            COMP: begin
                way_q        <= any_hit ? hit_num : repl_num;
                o_p_readdata <= word_of(i_rd_line[hit_num], word_sel);
                m_addr       <= req_line;
            end
            FETCH2: o_p_readdata <= word_of(i_m_readdata, word_sel);
            WB1: begin
                m_addr  <= i_wb_addr[way_q];
                m_wdata <= i_rd_line[way_q];
            end
            WB2: if (!i_m_waitrequest) m_addr <= req_line;  // fill follows the write-back
            default: ;
        endcase
    end

endmodule

// ==== verilog/cache_top.sv ====
/* 4-way write-back cache, 4-word lines
   memory side moves whole lines by line address */
`include "cache_params.svh"

module cache_top (
    input  logic               clk,
    input  logic               rst,
    input  cache_pkg::p_req_t  i_p_req,
    output logic               o_p_waitrequest,
    output cache_pkg::word_t   o_p_readdata,
    output logic               o_p_readdata_valid,
    output cache_pkg::m_req_t  o_m_req,
    input  cache_pkg::line_t   i_m_readdata,
    input  logic               i_m_readdata_valid,
    input  logic               i_m_waitrequest
);
    import cache_pkg::*;

    index_t                     index;
    tag_t                       tag;
    way_sel_t                   way_write;
    logic                       fill;
    logic [`CACHE_WORDS-1:0]    word_en;
    logic [`CACHE_WORD_W/8-1:0] byte_en;
    line_t                      wr_line;
    line_t                      rd_line [`CACHE_WAYS];
    way_stat_t                  way_stat [`CACHE_WAYS];
    line_addr_t                 wb_addr [`CACHE_WAYS];
    logic                       lru_clear;
    logic                       lru_access;
    way_num_t                   lru_way;
    way_num_t                   victim;

    cache_ctrl ctrl_inst (
        .clk                (clk),
        .rst                (rst),
        .i_p_req            (i_p_req),
        .o_p_waitrequest    (o_p_waitrequest),
        .o_p_readdata       (o_p_readdata),
        .o_p_readdata_valid (o_p_readdata_valid),
        .o_m_req            (o_m_req),
        .i_m_readdata       (i_m_readdata),
        .i_m_readdata_valid (i_m_readdata_valid),
        .i_m_waitrequest    (i_m_waitrequest),
        .o_index            (index),
        .o_tag              (tag),
        .o_write            (way_write),
        .o_fill             (fill),
        .o_word_en          (word_en),
        .o_byte_en          (byte_en),
        .o_wr_line          (wr_line),
        .i_stat             (way_stat),
        .i_rd_line          (rd_line),
        .i_wb_addr          (wb_addr),
        .o_lru_clear        (lru_clear),
        .o_lru_access       (lru_access),
        .o_lru_way          (lru_way),
        .i_victim           (victim)
    );

    for (genvar g = 0; g < `CACHE_WAYS; g++) begin : g_way
        cache_way way_inst (
            .clk       (clk),
            .i_index   (index),
            .i_tag     (tag),
            .i_write   (way_write[g]),
            .i_fill    (fill),
            .i_word_en (word_en),
            .i_byte_en (byte_en),
            .i_wr_line (wr_line),
            .o_rd_line (rd_line[g]),
            .o_stat    (way_stat[g]),
            .o_wb_addr (wb_addr[g])
        );
    end

    plru_tree plru_inst (
        .clk      (clk),
        .i_index  (index),
        .i_clear  (lru_clear),
        .i_access (lru_access),
        .i_way    (lru_way),
        .o_victim (victim)
    );

endmodule

// ==== testbench/mem_model.sv ====
/* line memory for the cache memory port, unwritten words read as addr ^ A5A50000
   waitrequest stalls are random; readdata_valid comes 1 to 4 cycles after acceptance */
`include "cache_params.svh"

module mem_model (
    input  logic                  clk,
    input  logic                  rst,
    input  cache_pkg::m_req_t     i_m_req,
    output cache_pkg::line_t      o_readdata,
    output logic                  o_readdata_valid,
    output logic                  o_waitrequest,
    output int                    o_rd_count,
    output int                    o_wr_count,
    output cache_pkg::line_addr_t o_wr_addr,
    output cache_pkg::line_t      o_wr_line
);
    timeunit 1ns;
    timeprecision 100ps;
    import cache_pkg::*;

    line_t      mem [line_addr_t];
    integer     seed = 11420;
    logic       pending;
    logic [1:0] delay;
    line_t      rd_line;

    function automatic line_t line_at(input line_addr_t la);
        line_t l;
        if (mem.exists(la)) return mem[la];
        for (int w = 0; w < `CACHE_WORDS; w++)
            l[w*`CACHE_WORD_W +: `CACHE_WORD_W] = {7'b0, la, 2'(w)} ^ 32'hA5A5_0000;
        return l;
    endfunction

    always @(posedge clk) begin
        if (rst) begin
            o_waitrequest    <= 1'b1;
            o_readdata_valid <= 1'b0;
            pending          <= 1'b0;
            o_rd_count       <= 0;
            o_wr_count       <= 0;
        end else begin
            o_readdata_valid <= 1'b0;
            o_waitrequest    <= (($random(seed) & 1) != 0);  // stall about half the cycles
            if (pending) begin
                if (delay == 2'd0) begin
                    o_readdata       <= rd_line;
                    o_readdata_valid <= 1'b1;
                    pending          <= 1'b0;
                end else begin
                    delay <= delay - 2'd1;
                end
            end
            if (i_m_req.read && !o_waitrequest) begin
                rd_line    <= line_at(i_m_req.addr);
                pending    <= 1'b1;
                delay      <= 2'($random(seed) & 3);
                o_rd_count <= o_rd_count + 1;
            end
            if (i_m_req.write && !o_waitrequest) begin
                mem[i_m_req.addr] = i_m_req.writedata;
                o_wr_count <= o_wr_count + 1;
                o_wr_addr  <= i_m_req.addr;
                o_wr_line  <= i_m_req.writedata;
            end
        end
    end

endmodule

// ==== testbench/tb_cache.sv ====
/* directed tests for cache_top against a model of tags, dirty bits and pseudo-LRU
   expected data comes from a word map seeded with the memory fill pattern */
`include "cache_params.svh"

module tb_cache;
    timeunit 1ns;
    timeprecision 100ps;
    import cache_pkg::*;

    localparam int timeout_cycles = 300;

    logic       clk;
    logic       rst;
    p_req_t     p_req;
    logic       p_waitrequest;
    word_t      p_readdata;
    logic       p_readdata_valid;
    m_req_t     m_req;
    line_t      m_readdata;
    logic       m_readdata_valid;
    logic       m_waitrequest;
    int         mem_reads;
    int         mem_writes;
    line_addr_t wb_addr;
    line_t      wb_line;
    int         value_errs = 0;
    int         timeout_errs = 0;

    word_t      gold [p_addr_t];
    tag_t       ref_tag [16][4];
    logic       ref_valid [16][4];
    logic       ref_dirty [16][4];
    logic [2:0] ref_lru [16];

    cache_top cache_top_inst (
        .clk(clk), .rst(rst), .i_p_req(p_req),
        .o_p_waitrequest(p_waitrequest), .o_p_readdata(p_readdata),
        .o_p_readdata_valid(p_readdata_valid), .o_m_req(m_req),
        .i_m_readdata(m_readdata), .i_m_readdata_valid(m_readdata_valid),
        .i_m_waitrequest(m_waitrequest)
    );

    mem_model mem_inst (
        .clk(clk), .rst(rst), .i_m_req(m_req), .o_readdata(m_readdata),
        .o_readdata_valid(m_readdata_valid), .o_waitrequest(m_waitrequest),
        .o_rd_count(mem_reads), .o_wr_count(mem_writes),
        .o_wr_addr(wb_addr), .o_wr_line(wb_line)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic check_word(input word_t got, input word_t exp, input string what);
        if (got !== exp) begin
            $display("FAILED at %0t: %s got %h expected %h", $time, what, got, exp);
            value_errs++;
        end
    endtask

    task automatic check_line(input line_t got, input line_t exp, input string what);
        if (got !== exp) begin
            $display("FAILED at %0t: %s got %h expected %h", $time, what, got, exp);
            value_errs++;
        end
    endtask

    task automatic check_addr(input line_addr_t got, input line_addr_t exp, input string what);
        if (got !== exp) begin
            $display("FAILED at %0t: %s got %h expected %h", $time, what, got, exp);
            value_errs++;
        end
    endtask

    task automatic check_count(input int got, input int exp, input string what);
        if (got != exp) begin
            $display("FAILED at %0t: %s got %0d expected %0d", $time, what, got, exp);
            value_errs++;
        end
    endtask

    function automatic word_t gold_word(input p_addr_t a);
        if (gold.exists(a)) return gold[a];
        return {7'b0, a} ^ 32'hA5A5_0000;
    endfunction

    function automatic line_t gold_line(input line_addr_t la);
        line_t l;
        for (int w = 0; w < 4; w++)
            l[w*32 +: 32] = gold_word({la, 2'(w)});
        return l;
    endfunction

    // tag, valid, dirty and tree update for one access
    function automatic void model_access(input p_addr_t a, input logic wr,
                                         output logic miss, output logic wb,
                                         output line_addr_t wb_la);
        index_t   idx;
        tag_t     tg;
        way_num_t way;
        logic     hit;
        idx = a[5:2];
        tg  = a[24:6];
        hit = 1'b0;
        way = '0;
        for (int w = 3; w >= 0; w--) begin
            if (ref_valid[idx][w] && ref_tag[idx][w] == tg) begin
                hit = 1'b1;
                way = way_num_t'(w);
            end
        end
        wb    = 1'b0;
        wb_la = '0;
        if (!hit) begin
            way = ref_lru[idx][0] ? {1'b1, ref_lru[idx][2]} : {1'b0, ref_lru[idx][1]};
            for (int w = 3; w >= 0; w--)
                if (!ref_valid[idx][w]) way = way_num_t'(w);  // invalid way first
            wb    = ref_valid[idx][way] && ref_dirty[idx][way];
            wb_la = {ref_tag[idx][way], idx};
            ref_tag[idx][way]   = tg;
            ref_valid[idx][way] = 1'b1;
            ref_dirty[idx][way] = wr;
        end else if (wr) begin
            ref_dirty[idx][way] = 1'b1;
        end
        miss = !hit;
        ref_lru[idx][0] = ~way[1];
        if (way[1]) ref_lru[idx][2] = ~way[0];
        else ref_lru[idx][1] = ~way[0];
    endfunction

    // one cycle of waitrequest per index after reset
    task automatic check_sweep();
        int n;
        n = 0;
        while (p_waitrequest && n < timeout_cycles) begin
            @(posedge clk);
            #1;
            n++;
        end
        check_count(n, 16, "reset sweep cycles");
    endtask

    // returns once the request has been taken
    task automatic accept_req();
        int n;
        n = 0;
        while (p_waitrequest && n < timeout_cycles) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (p_waitrequest) begin
            $display("timeout: cache never dropped waitrequest at %0t", $time);
            timeout_errs++;
        end
        @(posedge clk);
        #1;
        p_req.read  = 1'b0;
        p_req.write = 1'b0;
    endtask

    task automatic p_read(input p_addr_t a, output word_t data, output int lat);
        @(posedge clk);
        #1;
        p_req = '{addr: a, byte_en: 4'hf, writedata: '0, read: 1'b1, write: 1'b0};
        accept_req();
        lat = 0;
        do begin
            @(posedge clk);
            #1;
            lat++;
        end while (!p_readdata_valid && lat < timeout_cycles);
        if (!p_readdata_valid) begin
            $display("timeout: no read data for address %h at %0t", a, $time);
            timeout_errs++;
        end
        data = p_readdata;
    endtask

    task automatic p_write(input p_addr_t a, input logic [3:0] be, input word_t d,
                           output int lat);
        @(posedge clk);
        #1;
        p_req = '{addr: a, byte_en: be, writedata: d, read: 1'b0, write: 1'b1};
        accept_req();
        lat = 0;
        do begin
            @(posedge clk);
            #1;
            lat++;
        end while (p_waitrequest && lat < timeout_cycles);
        if (p_waitrequest) begin
            $display("timeout: write to address %h never completed at %0t", a, $time);
            timeout_errs++;
        end
    endtask

    task automatic check_traffic(input int r0, input int w0, input logic miss,
                                 input logic wb, input line_addr_t wb_la, input line_t exp_wb);
        check_count(mem_reads - r0, int'(miss), "memory reads");
        check_count(mem_writes - w0, int'(wb), "memory writes");
        if (wb) begin
            check_addr(wb_addr, wb_la, "write-back address");
            check_line(wb_line, exp_wb, "write-back line");
        end
    endtask

    task automatic do_read(input p_addr_t a);
        int         r0, w0, lat;
        logic       miss, wb;
        line_addr_t wb_la;
        word_t      data;
        r0 = mem_reads;
        w0 = mem_writes;
        model_access(a, 1'b0, miss, wb, wb_la);
        p_read(a, data, lat);
        check_word(data, gold_word(a), "read data");
        check_traffic(r0, w0, miss, wb, wb_la, gold_line(wb_la));
        if (!miss) check_count(lat, 1, "read hit latency");
    endtask

    task automatic do_write(input p_addr_t a, input logic [3:0] be, input word_t d);
        int         r0, w0, lat;
        logic       miss, wb;
        line_addr_t wb_la;
        line_t      exp_wb;
        word_t      w;
        r0 = mem_reads;
        w0 = mem_writes;
        model_access(a, 1'b1, miss, wb, wb_la);
        exp_wb = gold_line(wb_la);
        w = gold_word(a);
        for (int b = 0; b < 4; b++)
            if (be[b]) w[b*8 +: 8] = d[b*8 +: 8];
        gold[a] = w;
        p_write(a, be, d, lat);
        check_traffic(r0, w0, miss, wb, wb_la, exp_wb);
        if (!miss) check_count(lat, 2, "write hit latency");
    endtask

    function automatic p_addr_t addr_of(input int t, input int i, input int w);
        return {tag_t'(t), index_t'(i), 2'(w)};
    endfunction

    task automatic test_read_miss();
        do_read(addr_of(1, 0, 0));
    endtask

    task automatic test_read_hit();
        do_read(addr_of(1, 0, 1));
        do_read(addr_of(1, 0, 3));
    endtask

    task automatic test_write_hit();
        do_write(addr_of(1, 0, 2), 4'b0101, 32'h1122_3344);
        do_read(addr_of(1, 0, 2));
    endtask

    task automatic test_write_miss();
        do_write(addr_of(2, 1, 1), 4'b1100, 32'hDEAD_BEEF);
        for (int w = 0; w < 4; w++)
            do_read(addr_of(2, 1, w));
    endtask

    // ways 0..3 dirty, touch order 2,0,3,1 leaves way 2 (tag 3) as victim
    task automatic test_eviction();
        for (int t = 1; t <= 4; t++)
            do_write(addr_of(t, 3, 0), 4'b1111, 32'h5000_0000 + t);
        do_read(addr_of(3, 3, 1));
        do_read(addr_of(1, 3, 1));
        do_read(addr_of(4, 3, 1));
        do_read(addr_of(2, 3, 1));
        do_read(addr_of(5, 3, 2));
        check_addr(wb_addr, {tag_t'(3), index_t'(3)}, "evicted line");
        do_read(addr_of(3, 3, 0));  // refetch of the written-back line
    endtask

    initial begin
        p_req = '0;
        rst   = 1'b1;
        for (int i = 0; i < 16; i++) begin
            ref_lru[i] = '0;
            for (int w = 0; w < 4; w++) begin
                ref_valid[i][w] = 1'b0;
                ref_dirty[i][w] = 1'b0;
                ref_tag[i][w]   = '0;
            end
        end
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;
        check_count(int'(m_req.read) + int'(m_req.write) + int'(p_readdata_valid), 0,
                    "strobes after reset");
        check_sweep();
        test_read_miss();
        test_read_hit();
        test_write_hit();
        test_write_miss();
        test_eviction();
        $display("errors: %0d wrong values, %0d timeouts", value_errs, timeout_errs);
        if (value_errs == 0 && timeout_errs == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// ==== cache.f ====
+incdir+common
common/cache_pkg.sv
cache/cache_ram.sv
cache/cache_way.sv
cache/plru_tree.sv
cache/cache_ctrl.sv
verilog/cache_top.sv
testbench/mem_model.sv
testbench/tb_cache.sv

// ==== Makefile ====
TOP = tb_cache

compile:
	verilator --binary --timing --top-module $(TOP) -f cache.f -o $(TOP)

run: compile
	@out=$$(./obj_dir/$(TOP)); echo "$$out"; echo "$$out" | grep -q '^Test OK$$'

clean:
	rm -rf obj_dir

.PHONY: compile run clean
